/* common_pkg.sv */
package common_pkg;

    // machine word width, shared by every stage
    localparam int XLEN  = 32;
    localparam int REG_W = 5;            // 32 architectural registers

    typedef logic [XLEN-1:0]  word_t;    // address, instruction, immediate
    typedef logic [REG_W-1:0] reg_idx_t; // register index

    // byte step between sequential instructions
    localparam word_t PC_STEP = 32'd4;

    // bubble marker
    // all ones is never word aligned, so it can't collide with a real fetch PC
    localparam word_t NOP_PC = 32'hffff_ffff;

    // addi x0,x0,0 rides along with NOP_PC in a bubble
    localparam word_t NOP_IR = 32'h0000_0013;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_ILLEGAL = 7'b000_0000,   // anything not listed below
        OP_LUI     = 7'b011_0111,
        OP_AUIPC   = 7'b001_0111,
        OP_JAL     = 7'b110_1111,
        OP_JALR    = 7'b110_0111,
        OP_BRANCH  = 7'b110_0011,
        OP_LOAD    = 7'b000_0011,
        OP_STORE   = 7'b010_0011,
        OP_IMM     = 7'b001_0011,   // register-immediate alu ops
        OP_REG     = 7'b011_0011,   // register-register alu ops
        OP_SYSTEM  = 7'b111_0011
    } opcode_e;

    // immediate layouts
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE    // R-type and illegal words carry no immediate
    } imm_fmt_e;

    // field positions inside the instruction word
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;
    localparam int RD_LSB  = 7;
    localparam int RD_MSB  = 11;
    localparam int F3_LSB  = 12;
    localparam int F3_MSB  = 14;
    localparam int RS1_LSB = 15;
    localparam int RS1_MSB = 19;
    localparam int RS2_LSB = 20;
    localparam int RS2_MSB = 24;

    localparam int SIGN_BIT = 31;   // immediate sign always sits here

endpackage

/* cpu_imem.sv */
`timescale 1ns/1ns

// word array with combinational read and synchronous load port
module cpu_imem
    import common_pkg::*;
    #(
        parameter int IMEM_WORDS = 64   // depth, power of two
    )
    (
        input  wire logic  clk_i,         // clock

        // load port
        input  wire logic  imem_we_i,     // write strobe
        input  wire word_t imem_waddr_i,  // byte address
        input  wire word_t imem_wdata_i,  // word to store

        // fetch port
        input  wire word_t imem_addr_i,   // byte address
        output wire word_t imem_data_o    // word at that address, same cycle
    );

// index bits, upper address bits are dropped so the PC wraps
localparam int AW = $clog2(IMEM_WORDS);

word_t          mem_r [0:IMEM_WORDS-1];  // no reset, loaded by the testbench
logic  [AW-1:0] ridx_w;
logic  [AW-1:0] widx_w;

// byte address -> word index, skip bits [1:0]
assign ridx_w = imem_addr_i[AW+1:2];
assign widx_w = imem_waddr_i[AW+1:2];

always_ff @(posedge clk_i) begin
    if (imem_we_i) begin
        mem_r[widx_w] <= imem_wdata_i;
    end
end

// async read, fetch registers the result itself
assign imem_data_o = mem_r[ridx_w];

endmodule

/* cpu_if.sv */
`timescale 1ns/1ns

// instruction fetch stage
// fpc_r/fir_r is the pair sitting in fetch, pc_r/ir_r the pair offered to decode
module cpu_if
    import common_pkg::*;
    (
        input  wire logic  clk_i,        // clock
        input  wire logic  arst_n_i,     // async reset, active low
        input  wire logic  halt_i,       // freeze fetch, emit bubbles

        // from decode
        input  wire logic  ready_i,      // downstream may advance
        input  wire logic  jmp_valid_i,  // redirect strobe
        input  wire word_t jmp_addr_i,   // redirect target

        // instruction memory
        output wire word_t imem_addr_o,  // request address = next PC
        input  wire word_t imem_data_i,  // returned word

        // to decode
        output wire word_t pc_o,         // program counter
        output wire word_t ir_o          // instruction register
    );

word_t fpc_r;    // fetch PC
word_t fir_r;    // word fetched at fpc_r
logic  fvld_r;   // fpc_r/fir_r hold a real fetch
word_t pc_w;     // next fetch PC

word_t pc_r;
word_t ir_r;

// next PC
always_comb begin
    pc_w = fpc_r + PC_STEP;                    // sequential by default

    if (jmp_valid_i) begin
        pc_w = jmp_addr_i;                     // jump beats everything, halt too
    end else if (halt_i || !ready_i || !fvld_r) begin
        pc_w = fpc_r;                          // hold, also refetch 0 after reset
    end
end

// memory sees the PC we are about to register
assign imem_addr_o = pc_w;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        fpc_r  <= '0;
        fvld_r <= 1'b0;
    end else begin
        fpc_r  <= pc_w;
        fvld_r <= 1'b1;    // first edge after reset loads mem[0]
    end
end

// word for pc_w lands together with fpc_r
always_ff @(posedge clk_i) begin
    fir_r <= imem_data_i;
end

// output pair
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        pc_r <= NOP_PC;
        ir_r <= NOP_IR;
    end else if (jmp_valid_i) begin
        // fpc_r is the wrong-path word behind the jal, drop it
        pc_r <= NOP_PC;
        ir_r <= NOP_IR;
    end else if (ready_i) begin
        if (halt_i || !fvld_r) begin
            pc_r <= NOP_PC;    // halted, fpc_r waits in place
            ir_r <= NOP_IR;
        end else begin
            pc_r <= fpc_r;
            ir_r <= fir_r;
        end
    end
    // not ready -> hold
end

assign pc_o = pc_r;
assign ir_o = ir_r;

endmodule

/* cpu_id.sv */
`timescale 1ns/1ns

// instruction decode stage
// classifies the opcode, splits fields, builds the immediate, resolves jal
module cpu_id
    import common_pkg::*;
    import isa_pkg::*;
    (
        input  wire logic     clk_i,        // clock
        input  wire logic     arst_n_i,     // async reset, active low
        input  wire logic     ready_i,      // execute takes our output

        // from fetch
        input  wire word_t    pc_i,         // program counter
        input  wire word_t    ir_i,         // instruction

        // back to fetch
        output wire logic     jmp_valid_o,  // jal accepted this cycle
        output wire word_t    jmp_addr_o,   // jal target

        // decoded instruction
        output wire logic     valid_o,      // not a bubble
        output wire word_t    pc_o,
        output wire opcode_e  op_o,
        output wire reg_idx_t rd_o,
        output wire reg_idx_t rs1_o,
        output wire reg_idx_t rs2_o,
        output wire logic [2:0] funct3_o,
        output wire word_t    imm_o         // sign extended
    );

logic [6:0] opc_w;
opcode_e    op_w;
imm_fmt_e   fmt_w;
word_t      imm_i_w;
word_t      imm_s_w;
word_t      imm_b_w;
word_t      imm_u_w;
word_t      imm_j_w;
word_t      imm_w;
logic       jal_w;

word_t      pc_r;
opcode_e    op_r;
reg_idx_t   rd_r;
reg_idx_t   rs1_r;
reg_idx_t   rs2_r;
logic [2:0] funct3_r;
word_t      imm_r;

assign opc_w = ir_i[OPC_MSB:OPC_LSB];

// opcode classification
always_comb begin
    case (opc_w)
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_IMM, OP_REG, OP_SYSTEM: op_w = opcode_e'(opc_w);
        default:                                      op_w = OP_ILLEGAL;
    endcase
end

// which immediate layout goes with the opcode
always_comb begin
    case (op_w)
        OP_LOAD, OP_IMM, OP_JALR, OP_SYSTEM: fmt_w = IMM_I;
        OP_STORE:                            fmt_w = IMM_S;
        OP_BRANCH:                           fmt_w = IMM_B;
        OP_LUI, OP_AUIPC:                    fmt_w = IMM_U;
        OP_JAL:                              fmt_w = IMM_J;
        default:                             fmt_w = IMM_NONE;  // R-type, illegal
    endcase
end

// all five layouts, sign from bit 31
assign imm_i_w = {{20{ir_i[SIGN_BIT]}}, ir_i[31:20]};
assign imm_s_w = {{20{ir_i[SIGN_BIT]}}, ir_i[31:25], ir_i[11:7]};
assign imm_b_w = {{19{ir_i[SIGN_BIT]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
assign imm_u_w = {ir_i[31:12], 12'b0};
assign imm_j_w = {{11{ir_i[SIGN_BIT]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

always_comb begin
    case (fmt_w)
        IMM_I:   imm_w = imm_i_w;
        IMM_S:   imm_w = imm_s_w;
        IMM_B:   imm_w = imm_b_w;
        IMM_U:   imm_w = imm_u_w;
        IMM_J:   imm_w = imm_j_w;
        default: imm_w = '0;
    endcase
end

// jal needs no register value, so it resolves here
assign jal_w       = (op_w == OP_JAL) && (pc_i != NOP_PC);  // bubbles never jump
assign jmp_valid_o = jal_w && ready_i;                      // only when jal moves on
assign jmp_addr_o  = pc_i + imm_j_w;

// pc doubles as the valid flag
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        pc_r <= NOP_PC;
    end else if (ready_i) begin
        pc_r <= pc_i;
    end
end

always_ff @(posedge clk_i) begin
    if (ready_i) begin
        op_r     <= op_w;
        rd_r     <= ir_i[RD_MSB:RD_LSB];
        rs1_r    <= ir_i[RS1_MSB:RS1_LSB];
        rs2_r    <= ir_i[RS2_MSB:RS2_LSB];
        funct3_r <= ir_i[F3_MSB:F3_LSB];
        imm_r    <= imm_w;
    end
end

assign valid_o  = (pc_r != NOP_PC);
assign pc_o     = pc_r;
assign op_o     = op_r;
assign rd_o     = rd_r;
assign rs1_o    = rs1_r;
assign rs2_o    = rs2_r;
assign funct3_o = funct3_r;
assign imm_o    = imm_r;

endmodule

/* cpu_frontend.sv */
`timescale 1ns/1ns

// fetch + imem + decode
module cpu_frontend
    import common_pkg::*;
    import isa_pkg::*;
    #(
        parameter int IMEM_WORDS = 64           // instruction memory depth
    )
    (
        input  wire logic       clk_i,          // clock
        input  wire logic       arst_n_i,       // async reset, active low
        input  wire logic       halt_i,         // freeze fetch
        input  wire logic       ex_ready_i,     // execute can take a decoded instr

        // program load
        input  wire logic       imem_we_i,
        input  wire word_t      imem_waddr_i,
        input  wire word_t      imem_wdata_i,

        // decoded instruction out
        output wire logic       id_valid_o,
        output wire word_t      id_pc_o,
        output wire opcode_e    id_op_o,
        output wire reg_idx_t   id_rd_o,
        output wire reg_idx_t   id_rs1_o,
        output wire reg_idx_t   id_rs2_o,
        output wire logic [2:0] id_funct3_o,
        output wire word_t      id_imm_o
    );

word_t imem_addr;   // fetch -> imem
word_t imem_data;   // imem -> fetch, same cycle
word_t if_pc;       // fetch -> decode
word_t if_ir;
logic  jmp_valid;   // decode -> fetch redirect
word_t jmp_addr;

cpu_imem #(
    .IMEM_WORDS   (IMEM_WORDS)
) u_imem (
    .clk_i        (clk_i),
    .imem_we_i    (imem_we_i),
    .imem_waddr_i (imem_waddr_i),
    .imem_wdata_i (imem_wdata_i),
    .imem_addr_i  (imem_addr),
    .imem_data_o  (imem_data)
);

cpu_if u_if (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .halt_i       (halt_i),
    .ready_i      (ex_ready_i),   // no decode stall, so execute readiness goes straight through
    .jmp_valid_i  (jmp_valid),
    .jmp_addr_i   (jmp_addr),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .pc_o         (if_pc),
    .ir_o         (if_ir)
);

cpu_id u_id (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ready_i      (ex_ready_i),
    .pc_i         (if_pc),
    .ir_i         (if_ir),
    .jmp_valid_o  (jmp_valid),
    .jmp_addr_o   (jmp_addr),
    .valid_o      (id_valid_o),
    .pc_o         (id_pc_o),
    .op_o         (id_op_o),
    .rd_o         (id_rd_o),
    .rs1_o        (id_rs1_o),
    .rs2_o        (id_rs2_o),
    .funct3_o     (id_funct3_o),
    .imm_o        (id_imm_o)
);

endmodule

/* cpu_frontend_chk.sv */
`timescale 1ns/1ns

// interface rules of fetch and decode, bound into cpu_frontend
module cpu_frontend_chk
    import common_pkg::*;
    import isa_pkg::*;
    (
        input  wire logic    clk_i,
        input  wire logic    arst_n_i,
        input  wire logic    ex_ready_i,
        input  wire logic    jmp_valid_i,   // decode -> fetch redirect
        input  wire logic    id_valid_i,
        input  wire word_t   id_pc_i,
        input  wire opcode_e id_op_i
    );

int n_jmp   = 0;    // failures per assertion
int n_rst   = 0;
int n_align = 0;
int fail_cnt;

assign fail_cnt = n_jmp + n_rst + n_align;

// a jal only redirects when it actually leaves decode, and only for one cycle
a_jmp_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    jmp_valid_i |-> ex_ready_i ##1 (id_valid_i && id_op_i == OP_JAL && !jmp_valid_i))
    else begin
        n_jmp++;
        $error("jump strobe high without the jal being accepted by execute");
    end

// first cycle out of reset carries no instruction
a_rst_quiet: assert property (@(posedge clk_i)
    $rose(arst_n_i) |=> !id_valid_i)
    else begin
        n_rst++;
        $error("decode output valid right after reset release");
    end

a_pc_align: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    id_valid_i |-> (id_pc_i[1:0] == 2'b00))
    else begin
        n_align++;
        $error("valid decode pc is not word aligned");
    end

endmodule

bind cpu_frontend cpu_frontend_chk u_chk (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ex_ready_i  (ex_ready_i),
    .jmp_valid_i (jmp_valid),
    .id_valid_i  (id_valid_o),
    .id_pc_i     (id_pc_o),
    .id_op_i     (id_op_o)
);

/* tb_cpu_frontend.sv */
`timescale 1ns/1ns

module tb_cpu_frontend
    import common_pkg::*;
    import isa_pkg::*;
    ();

localparam int IMEM_WORDS   = 64;
localparam int AW           = $clog2(IMEM_WORDS);
localparam int RESET_CYCLES = 16;
localparam int N_STRAIGHT   = 200;   // > 64 words, so the walk wraps
localparam int N_STALL      = 200;
localparam int N_HALT       = 200;
localparam int N_RESUME     = 50;
localparam int HALT_HOLD    = 40;    // cycles checked inside the long halt
localparam int TOTAL_INSNS  = N_STRAIGHT + N_STALL + N_HALT + N_RESUME;
localparam int WATCHDOG     = TOTAL_INSNS * 8 + 200;

logic       clk_i, arst_n_i, halt_i, ex_ready_i, imem_we_i;
word_t      imem_waddr_i, imem_wdata_i;
logic       id_valid_o;
word_t      id_pc_o, id_imm_o;
opcode_e    id_op_o;
reg_idx_t   id_rd_o, id_rs1_o, id_rs2_o;
logic [2:0] id_funct3_o;

word_t   prog    [0:IMEM_WORDS-1];   // program image
opcode_e exp_op  [0:IMEM_WORDS-1];   // expected class per word
word_t   exp_imm [0:IMEM_WORDS-1];   // immediate as chosen at generation
integer  seed;
int      errors, test_errors, consumed;
word_t   model_pc;                   // reference walk
string   test_name;

cpu_frontend #(.IMEM_WORDS(IMEM_WORDS)) uut (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .halt_i(halt_i), .ex_ready_i(ex_ready_i),
    .imem_we_i(imem_we_i), .imem_waddr_i(imem_waddr_i), .imem_wdata_i(imem_wdata_i),
    .id_valid_o(id_valid_o), .id_pc_o(id_pc_o), .id_op_o(id_op_o), .id_rd_o(id_rd_o),
    .id_rs1_o(id_rs1_o), .id_rs2_o(id_rs2_o), .id_funct3_o(id_funct3_o), .id_imm_o(id_imm_o)
);

always #50 clk_i = ~clk_i;

function automatic logic is_opcode(input logic [6:0] opc);
    case (opc)
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_IMM, OP_REG, OP_SYSTEM: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// builds each word from a chosen immediate, the rest of the bits stay random
task automatic gen_program();
    int    k, kind, v;
    word_t w, j, r;
    for (k = 0; k < IMEM_WORDS; k++) begin
        w    = $random(seed);
        kind = int'($unsigned($random(seed)) % 12);
        v    = $random(seed) % 2048;          // 12-bit signed range
        j    = v;
        if (kind < 2 && k > IMEM_WORDS - 3) begin
            kind = 2;                          // no forward room left
        end
        case (kind)
            0, 1: begin                        // jal, forward, skips at least one word
                j = 4 * (2 + int'($unsigned($random(seed)) % (IMEM_WORDS - 2 - k)));
                w[31] = j[20];
                w[30:21] = j[10:1];
                w[20] = j[11];
                w[19:12] = j[19:12];
                w[6:0] = OP_JAL;
                exp_op[k] = OP_JAL;
            end
            2, 3, 6, 7: begin                  // I-type
                w[31:20] = j[11:0];
                w[6:0] = (kind < 6) ? OP_IMM : OP_LOAD;
                exp_op[k] = (kind < 6) ? OP_IMM : OP_LOAD;
            end
            8, 9: begin
                w[31:25] = j[11:5];
                w[11:7] = j[4:0];
                w[6:0] = OP_STORE;
                exp_op[k] = OP_STORE;
            end
            10: begin
                j = $random(seed);
                j[11:0] = '0;                  // upper immediate only
                w[31:12] = j[31:12];
                w[6:0] = OP_LUI;
                exp_op[k] = OP_LUI;
            end
            default: begin                     // R-type or garbage opcode
                j = '0;
                if (kind == 11) begin
                    do begin
                        r = $random(seed);
                    end while (is_opcode(r[6:0]));
                    w[6:0] = r[6:0];
                    exp_op[k] = OP_ILLEGAL;
                end else begin
                    w[6:0] = OP_REG;
                    exp_op[k] = OP_REG;
                end
            end
        endcase
        prog[k]    = w;
        exp_imm[k] = j;
    end
endtask

// load port is one word per clock, so loading outlasts reset; fetch stays halted
task automatic load_program();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
        @(posedge clk_i);
        #1;
        if (i == RESET_CYCLES - 1) begin
            arst_n_i = 1'b1;
        end
        imem_we_i    = 1'b1;
        imem_waddr_i = i * 4;
        imem_wdata_i = prog[i];
    end
    @(posedge clk_i);
    #1;
    imem_we_i = 1'b0;
endtask

task automatic check_word(input string field, input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("FAILED %s %s: expected %h actual %h", test_name, field, exp, act);
        errors++;
        test_errors++;
    end
endtask

task automatic check_op(input string field, input opcode_e exp, input opcode_e act);
    if (act !== exp) begin
        $display("FAILED %s %s: expected %s actual %s", test_name, field, exp.name(), act.name());
        errors++;
        test_errors++;
    end
endtask

task automatic check_reg(input string field, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
        $display("FAILED %s %s: expected %0d actual %0d", test_name, field, exp, act);
        errors++;
        test_errors++;
    end
endtask

// one model entry per accepted output; a wrong-path word after a jal shows up as a pc mismatch
always @(negedge clk_i) begin : consume
    int    idx;
    word_t w;
    if (arst_n_i && id_valid_o && ex_ready_i) begin
        idx = int'(model_pc[AW+1:2]);          // same wrap as the memory
        w   = prog[idx];
        check_word("id_pc", model_pc, id_pc_o);
        check_op("id_op", exp_op[idx], id_op_o);
        check_reg("id_rd", w[11:7], id_rd_o);
        check_reg("id_rs1", w[19:15], id_rs1_o);
        check_reg("id_rs2", w[24:20], id_rs2_o);
        check_word("id_funct3", {29'b0, w[14:12]}, {29'b0, id_funct3_o});
        check_word("id_imm", exp_imm[idx], id_imm_o);
        model_pc = (exp_op[idx] == OP_JAL) ? model_pc + exp_imm[idx] : model_pc + 4;
        consumed++;
    end
end

task automatic run_test(input string name, input int n, input int ready_pct, input int halt_pct);
    int start;
    test_name   = name;
    test_errors = 0;
    start       = consumed;
    while (consumed < start + n) begin
        @(posedge clk_i);
        #1;
        ex_ready_i = ($unsigned($random(seed)) % 100) < ready_pct;
        halt_i     = ($unsigned($random(seed)) % 100) < halt_pct;
    end
    $display("test %-12s %0d instructions, %0d errors", name, consumed - start, test_errors);
endtask

task automatic long_halt();
    int start, c;
    test_name   = "long_halt";
    test_errors = 0;
    start       = consumed;
    @(posedge clk_i);
    #1;
    halt_i     = 1'b1;
    ex_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);               // fetch and decode registers drain
    for (c = 0; c < HALT_HOLD; c++) begin
        @(negedge clk_i);
        if (id_valid_o) begin
            $display("long_halt: a valid instruction reached decode output during the halt");
            errors++;
            test_errors++;
        end
    end
    $display("test %-12s %0d instructions, %0d errors", test_name, consumed - start, test_errors);
endtask

initial begin
    seed         = 32'h8f2b_0229;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    halt_i       = 1'b1;
    ex_ready_i   = 1'b1;
    imem_we_i    = 1'b0;
    imem_waddr_i = '0;
    imem_wdata_i = '0;
    errors       = 0;
    test_errors  = 0;
    consumed     = 0;
    model_pc     = '0;
    test_name    = "load";
    gen_program();
    load_program();
    run_test("straight", N_STRAIGHT, 100, 0);
    run_test("backpressure", N_STALL, 60, 0);
    run_test("halt_mix", N_HALT, 70, 25);
    long_halt();
    run_test("resume", N_RESUME, 80, 10);
    $display("summary: %0d instructions, %0d check errors, %0d assertion failures",
             consumed, errors, uut.u_chk.fail_cnt);
    if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

// watchdog
initial begin
    repeat (WATCHDOG) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG);
    $display("TB FAILED");
    $finish;
end

endmodule

/* sim.f */
common_pkg.sv
isa_pkg.sv
cpu_imem.sv
cpu_if.sv
cpu_id.sv
cpu_frontend.sv
cpu_frontend_chk.sv
tb_cpu_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_cpu_frontend -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
